/* compile.f */
+incdir+logic
logic/mipsPkg.sv
logic/registerFile.sv
logic/alu.sv
logic/controlUnit.sv
logic/datapath.sv
logic/mipsCore.sv
tests/memoryModel.sv
tests/mipsCoreTb.sv

/* run.sh */
#!/bin/bash
# Build and run the mipsCore testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f compile.f --top-module mipsCoreTb -o simv \
	&& ./obj_dir/simv 2>&1 | tee sim.log

grep -qx "Verification passed" sim.log && echo "PASS" && exit 0 \
	|| { echo "FAIL"; exit 1; }

/* tests/mipsCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
	import mipsPkg::*;

	localparam logic [31:0] lfsrSeed = 32'he96b_cf01;
	localparam int dataBase = 32'h1000; // Stores go above the program
	localparam int groupCount = 48;

	logic  CLK;
	logic  reset;
	logic  memReady;
	word_t memReadData;
	logic  memRead;
	logic  memWrite;
	word_t memAddr;
	word_t memWriteData;

	logic [31:0] lfsr;
	word_t refRegs [32]; // Reference register state
	word_t prog [$];
	word_t expAddr [$];
	word_t expData [$];
	int    storeIdx;
	int    timeoutLimit;
	int    cycleCount;
	logic  prevReset;
	logic  prevRead;
	logic  prevWrite;
	logic  prevReady;
	logic  firstReadSeen;
	word_t prevAddr;
	word_t prevData;

	logic [5:0] rFuncts [13] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26,
		6'h27, 6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03};
	logic [5:0] iOps [8] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

	mipsCore u_mipsCore (
		.CLK (CLK), .reset (reset), .memReady (memReady), .memReadData (memReadData),
		.memRead (memRead), .memWrite (memWrite), .memAddr (memAddr),
		.memWriteData (memWriteData)
	);

	memoryModel #(.lfsrSeed (lfsrSeed)) u_memoryModel (
		.CLK (CLK), .reset (reset), .memRead (memRead), .memWrite (memWrite),
		.memAddr (memAddr), .memWriteData (memWriteData), .memReady (memReady),
		.memReadData (memReadData)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK; // 8 ns period
	end

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [4:0] pickReg();
		return 5'(1 + randBits(3) % 7); // Never $0
	endfunction

	function automatic word_t encR(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t encI(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Expected result from the MIPS instruction rules
	function automatic word_t refAlu(input logic [5:0] op, input logic [5:0] fn,
			input logic [4:0] sh, input word_t a, input word_t b, input logic [15:0] imm);
		word_t sImm;
		word_t zImm;
		sImm = {{16{imm[15]}}, imm};
		zImm = {16'h0000, imm};
		case (op)
			6'h00: begin
				case (fn)
					6'h20, 6'h21: return a + b;
					6'h22, 6'h23: return a - b;
					6'h24:        return a & b;
					6'h25:        return a | b;
					6'h26:        return a ^ b;
					6'h27:        return ~(a | b);
					6'h2a:        return {31'd0, $signed(a) < $signed(b)};
					6'h2b:        return {31'd0, a < b};
					6'h00:        return b << sh;
					6'h02:        return b >> sh;
					default:      return $signed(b) >>> sh; // SRA
				endcase
			end
			6'h08, 6'h09: return a + sImm;
			6'h0a:        return {31'd0, $signed(a) < $signed(sImm)};
			6'h0b:        return {31'd0, a < sImm}; // Unsigned compare
			6'h0c:        return a & zImm;
			6'h0d:        return a | zImm;
			6'h0e:        return a ^ zImm;
			default:      return {imm, 16'h0000}; // LUI
		endcase
	endfunction

	task automatic setReg(input logic [4:0] r, input word_t v);
		prog.push_back(encI(6'h0f, 5'd0, r, v[31:16]));
		prog.push_back(encI(6'h0d, r, r, v[15:0]));
		if (r != 5'd0)
			refRegs[r] = v;
	endtask

	function automatic word_t emitStore(input logic [4:0] r, input logic expected);
		word_t addr;
		addr = word_t'(dataBase + 4 * storeIdx); // Each store gets a fresh word
		storeIdx++;
		prog.push_back(encI(6'h2b, 5'd0, r, addr[15:0]));
		if (expected) begin
			expAddr.push_back(addr);
			expData.push_back(refRegs[r]);
		end
		return addr;
	endfunction

	task automatic aluGroup(input logic [4:0] idx);
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] dst;
		logic [4:0] sh;
		logic [5:0] code;
		logic [15:0] imm;
		word_t res;
		rs = pickReg();
		rt = pickReg();
		setReg(rs, randBits(32));
		setReg(rt, randBits(32));
		dst = (randBits(3) == 0) ? 5'd0 : pickReg(); // Sometimes targets $0
		sh  = 5'(randBits(5));
		imm = 16'(randBits(16));
		if (idx < 5'd13) begin
			code = rFuncts[idx];
			prog.push_back(encR(code, rs, rt, dst, sh));
			res = refAlu(6'h00, code, sh, refRegs[rs], refRegs[rt], imm);
		end else begin
			code = iOps[idx - 5'd13];
			prog.push_back(encI(code, rs, dst, imm));
			res = refAlu(code, 6'h00, sh, refRegs[rs], refRegs[rt], imm);
		end
		if (dst != 5'd0)
			refRegs[dst] = res;
		void'(emitStore(dst, 1'b1));
	endtask

	task automatic branchGroup(input logic [1:0] kind, input logic [1:0] mode);
		logic [4:0] rs;
		logic [4:0] rt;
		logic [5:0] op;
		logic taken;
		word_t a;
		word_t b;
		rs   = pickReg();
		rt   = pickReg();
		setReg(rs, (mode == 2'd1) ? 32'd0 : randBits(32));
		setReg(rt, (mode == 2'd0) ? refRegs[rs] : randBits(32)); // Equal operands
		a = refRegs[rs];
		b = refRegs[rt];
		case (kind)
			2'd0: begin
				op    = 6'h04;
				taken = (a == b);
			end
			2'd1: begin
				op    = 6'h05;
				taken = (a != b);
			end
			2'd2: begin
				op    = 6'h07;
				taken = ($signed(a) > 0);
			end
			default: begin
				op    = 6'h06;
				taken = ($signed(a) <= 0);
			end
		endcase
		prog.push_back(encI(op, rs, kind[1] ? 5'd0 : rt, 16'd1)); // Skips one store
		void'(emitStore(rs, !taken));
		void'(emitStore(rt, 1'b1));
	endtask

	task automatic loadStoreGroup();
		logic [4:0] src;
		logic [4:0] dst;
		word_t addr;
		src = pickReg();
		setReg(src, randBits(32));
		addr = emitStore(src, 1'b1);
		dst = (randBits(2) == 0) ? 5'd0 : pickReg();
		prog.push_back(encI(6'h23, 5'd0, dst, addr[15:0]));
		if (dst != 5'd0)
			refRegs[dst] = refRegs[src];
		void'(emitStore(dst, 1'b1));
	endtask

	task automatic failRun();
		$display("Verification failed");
		$fatal(1, "Stopping at the first failure");
	endtask

	task automatic reportError(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		failRun();
	endtask

	// Bus protocol and store checks at each rising edge
	always @(posedge CLK) begin
		if (reset || prevReset)
			assert (!memRead && !memWrite) else reportError("request during or just after reset");
		assert (!(memRead && memWrite)) else reportError("memRead and memWrite high together");
		if (memRead && !firstReadSeen) begin
			firstReadSeen = 1'b1;
			assert (memAddr == 32'd0) else reportError($sformatf("first fetch at %h", memAddr));
		end
		if ((prevRead || prevWrite) && !prevReady)
			assert (memRead == prevRead && memWrite == prevWrite && memAddr == prevAddr
				&& (!prevWrite || memWriteData == prevData))
			else reportError("request changed before memReady");
		if (prevReady)
			assert (!memRead && !memWrite) else reportError("request still high after memReady");
		if (memWrite && memReady) begin
			assert (expAddr.size() != 0) else reportError("store beyond the expected sequence");
			assert (memAddr == expAddr[0])
			else reportError($sformatf("store address %h, expected %h", memAddr, expAddr[0]));
			assert (memWriteData == expData[0])
			else reportError($sformatf("store data %h at %h, expected %h", memWriteData,
				memAddr, expData[0]));
			void'(expAddr.pop_front());
			void'(expData.pop_front());
		end
		prevReset = reset;
		prevRead  = memRead;
		prevWrite = memWrite;
		prevReady = memReady;
		prevAddr  = memAddr;
		prevData  = memWriteData;
	end

	always @(posedge CLK) begin
		if (!reset && timeoutLimit > 0) begin
			cycleCount++;
			if (cycleCount > timeoutLimit) begin
				$display("Timeout: the core did not finish the program in %0d cycles",
					timeoutLimit);
				failRun();
			end
		end
	end

	initial begin
		reset         = 1'b1;
		lfsr          = lfsrSeed;
		storeIdx      = 0;
		cycleCount    = 0;
		timeoutLimit  = 0;
		prevReset     = 1'b1;
		prevRead      = 1'b0;
		prevWrite     = 1'b0;
		prevReady     = 1'b0;
		firstReadSeen = 1'b0;
		prevAddr      = '0;
		prevData      = '0;
		for (int i = 0; i < 32; i++)
			refRegs[i] = '0;
		for (int i = 0; i < 2048; i++)
			u_memoryModel.mem[i] = {5'b10101, i[10:0], 5'b01010, i[10:0]};
		for (int k = 0; k < 21; k++)
			aluGroup(5'(k)); // Every ALU operation at least once
		for (int k = 0; k < 16; k++)
			branchGroup(2'(k / 4), 2'(k)); // Each branch with each operand mode
		for (int g = 0; g < groupCount; g++) begin
			case (randBits(2))
				32'd0, 32'd1: aluGroup(5'(randBits(5) % 21));
				32'd2:        branchGroup(2'(randBits(2)), 2'(randBits(2)));
				default:      loadStoreGroup();
			endcase
		end
		prog.push_back(encI(6'h04, 5'd0, 5'd0, 16'hffff)); // BEQ $0,$0 to itself
		for (int i = 0; i < prog.size(); i++)
			u_memoryModel.mem[i] = prog[i];
		timeoutLimit = prog.size() * 13 + 200;
		repeat (5) @(posedge CLK);
		reset <= 1'b0;
		while (expAddr.size() != 0)
			@(posedge CLK);
		repeat (40) @(posedge CLK); // Room for a stray store to show up
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/memoryModel.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryModel #(
	parameter logic [31:0] lfsrSeed = 32'he96b_cf01
) (
	input  logic           CLK,
	input  logic           reset,
	input  logic           memRead,
	input  logic           memWrite,
	input  mipsPkg::word_t memAddr,
	input  mipsPkg::word_t memWriteData,
	output logic           memReady,
	output mipsPkg::word_t memReadData
);
	import mipsPkg::*;

	word_t      mem [2048]; // Loaded by the testbench before reset ends
	logic [31:0] lfsr;
	logic       busy;
	logic [1:0] waitCount;
	logic [1:0] latency;

	// Galois LFSR, one step per bit taken
	function automatic logic [1:0] latencyBits();
		logic [1:0] v;
		v = '0;
		for (int i = 0; i < 2; i++) begin
			v = {v[0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	initial begin
		lfsr        = lfsrSeed;
		memReady    = 1'b0;
		memReadData = '0;
	end

	// Completes the pending request, memReady high for one cycle
	task automatic complete();
		memReady <= 1'b1;
		if (memRead)
			memReadData <= mem[memAddr[12:2]];
		if (memWrite)
			mem[memAddr[12:2]] <= memWriteData; // Stored word as is
	endtask

	always @(posedge CLK) begin
		if (reset) begin
			memReady <= 1'b0;
			busy     <= 1'b0;
		end else if (memReady) begin
			memReady <= 1'b0; // Request still seen high at this edge
			busy     <= 1'b0;
		end else if (busy) begin
			if (waitCount == 2'd0)
				complete();
			else
				waitCount <= waitCount - 2'd1;
		end else if (memRead || memWrite) begin
			latency = latencyBits();
			if (latency == 2'd0) begin
				complete();
			end else begin
				busy      <= 1'b1;
				waitCount <= latency - 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
	input  logic           CLK,
	input  logic           reset,
	input  logic           memReady,
	input  mipsPkg::word_t memReadData,
	output logic           memRead,
	output logic           memWrite,
	output mipsPkg::word_t memAddr,
	output mipsPkg::word_t memWriteData
);
	import mipsPkg::*;

	opcode_e    opcode;
	logic       pcWrite;
	logic       irWrite;
	logic       addrWrite;
	logic       dataWrite;
	logic       operandWrite;
	logic       regWrite;
	logic       branch;
	logic       addrFromAlu;
	logic       loadToReg;
	regDstSel_e regDstSel;
	aluSrcSel_e aluSrcSel;
	aluMode_e   aluMode;

	controlUnit u_controlUnit (
		.CLK (CLK), .reset (reset), .memReady (memReady), .opcode (opcode),
		.memRead (memRead), .memWrite (memWrite), .pcWrite (pcWrite), .irWrite (irWrite),
		.addrWrite (addrWrite), .dataWrite (dataWrite), .operandWrite (operandWrite),
		.regWrite (regWrite), .branch (branch), .addrFromAlu (addrFromAlu),
		.loadToReg (loadToReg), .regDstSel (regDstSel), .aluSrcSel (aluSrcSel), .aluMode (aluMode)
	);

	datapath u_datapath (
		.CLK (CLK), .reset (reset), .pcWrite (pcWrite), .irWrite (irWrite),
		.addrWrite (addrWrite), .dataWrite (dataWrite), .operandWrite (operandWrite),
		.regWrite (regWrite), .branch (branch), .addrFromAlu (addrFromAlu),
		.loadToReg (loadToReg), .regDstSel (regDstSel), .aluSrcSel (aluSrcSel),
		.aluMode (aluMode), .memReadData (memReadData), .opcode (opcode),
		.memAddr (memAddr), .memWriteData (memWriteData)
	);

endmodule

`default_nettype wire

/* logic/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsDefs_defs.svh"

module datapath (
	input  logic                CLK,
	input  logic                reset,
	input  logic                pcWrite,
	input  logic                irWrite,
	input  logic                addrWrite,
	input  logic                dataWrite,
	input  logic                operandWrite,
	input  logic                regWrite,
	input  logic                branch,
	input  logic                addrFromAlu,
	input  logic                loadToReg,
	input  mipsPkg::regDstSel_e regDstSel,
	input  mipsPkg::aluSrcSel_e aluSrcSel,
	input  mipsPkg::aluMode_e   aluMode,
	input  mipsPkg::word_t      memReadData,
	output mipsPkg::opcode_e    opcode,
	output mipsPkg::word_t      memAddr,
	output mipsPkg::word_t      memWriteData
);
	import mipsPkg::*;

	word_t    pc;
	word_t    instr;
	word_t    loadData;
	word_t    opA;
	word_t    opB;
	word_t    rfDataA;
	word_t    rfDataB;
	word_t    signImm;
	word_t    zeroImm;
	word_t    aluOperandB;
	word_t    aluResult;
	logic     aluZero;
	word_t    writeData;
	regAddr_t writeAddr;
	word_t    pcPlusFour;
	word_t    branchTarget;
	logic     branchTaken;

	assign opcode  = opcode_e'(instr[31:26]);
	assign signImm = {{16{instr[15]}}, instr[15:0]};
	assign zeroImm = {16'h0000, instr[15:0]};

	// PC already points past the branch here
	assign pcPlusFour   = pc + 32'd4;
	assign branchTarget = pc + {signImm[29:0], 2'b00};

	always_ff @(posedge CLK) begin
		if (reset)
			pc <= `MIPS_RESET_PC;
		else if (pcWrite)
			pc <= pcPlusFour;
		else if (branch && branchTaken)
			pc <= branchTarget;
	end

	always_ff @(posedge CLK) begin
		if (irWrite)
			instr <= memReadData;
		if (addrWrite)
			memAddr <= addrFromAlu ? aluResult : pc; // Effective address or fetch
		if (dataWrite)
			loadData <= memReadData;
		if (operandWrite) begin
			opA          <= rfDataA;
			opB          <= rfDataB;
			memWriteData <= rfDataB; // Store data from rt
		end
	end

	always_comb begin
		case (aluSrcSel)
			srcSignImm: aluOperandB = signImm;
			srcZeroImm: aluOperandB = zeroImm;
			default:    aluOperandB = opB;
		endcase
	end

	// Branch condition, evaluated only while branch is marked
	always_comb begin
		case (opcode)
			opBeq:   branchTaken = aluZero;
			opBne:   branchTaken = !aluZero;
			opBgtz:  branchTaken = $signed(opA) > 0;
			opBlez:  branchTaken = $signed(opA) <= 0;
			default: branchTaken = 1'b0;
		endcase
	end

	assign writeAddr = (regDstSel == dstRd) ? instr[15:11] : instr[20:16];
	assign writeData = loadToReg ? loadData : aluResult;

	registerFile u_registerFile (
		.CLK         (CLK),
		.reset       (reset),
		.writeEnable (regWrite),
		.readAddrA   (instr[25:21]),
		.readAddrB   (instr[20:16]),
		.writeAddr   (writeAddr),
		.writeData   (writeData),
		.readDataA   (rfDataA),
		.readDataB   (rfDataB)
	);

	alu u_alu (
		.aluMode  (aluMode),
		.funct    (funct_e'(instr[5:0])),
		.shamt    (instr[10:6]),
		.operandA (opA),
		.operandB (aluOperandB),
		.result   (aluResult),
		.zero     (aluZero)
	);

endmodule

`default_nettype wire

/* logic/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input  logic                CLK,
	input  logic                reset,
	input  logic                memReady,
	input  mipsPkg::opcode_e    opcode,
	output logic                memRead,
	output logic                memWrite,
	output logic                pcWrite,
	output logic                irWrite,
	output logic                addrWrite,
	output logic                dataWrite,
	output logic                operandWrite,
	output logic                regWrite,
	output logic                branch,
	output logic                addrFromAlu,
	output logic                loadToReg,
	output mipsPkg::regDstSel_e regDstSel,
	output mipsPkg::aluSrcSel_e aluSrcSel,
	output mipsPkg::aluMode_e   aluMode
);
	import mipsPkg::*;

	cuState_e state;
	cuState_e nextState;
	logic     isAluOp; // R-type or immediate ALU instruction
	logic     isBranch;
	logic     isLoad;
	logic     isStore;

	// Instruction class and ALU setup from the opcode
	always_comb begin
		isAluOp   = 1'b0;
		isBranch  = 1'b0;
		isLoad    = 1'b0;
		isStore   = 1'b0;
		aluMode   = aluAdd;
		aluSrcSel = srcRegB;
		case (opcode)
			opRType: begin
				isAluOp = 1'b1;
				aluMode = aluFunct;
			end
			opAddi, opAddiu: begin
				isAluOp   = 1'b1;
				aluSrcSel = srcSignImm;
			end
			opSlti, opSltiu: begin
				isAluOp   = 1'b1;
				aluMode   = (opcode == opSlti) ? aluSlt : aluSltu;
				aluSrcSel = srcSignImm; // SLTIU still sign-extends
			end
			opAndi, opOri, opXori, opLui: begin
				isAluOp   = 1'b1;
				aluSrcSel = srcZeroImm;
				case (opcode)
					opAndi:  aluMode = aluAnd;
					opOri:   aluMode = aluOr;
					opXori:  aluMode = aluXor;
					default: aluMode = aluLui;
				endcase
			end
			opBeq, opBne, opBgtz, opBlez: begin
				isBranch = 1'b1;
				aluMode  = aluSub; // Zero flag for the equality test
			end
			opLw, opSw: begin
				isLoad    = (opcode == opLw);
				isStore   = (opcode == opSw);
				aluSrcSel = srcSignImm; // Base plus offset
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset)
			state <= fetch;
		else
			state <= nextState;
	end

	// Next state and datapath enables
	always_comb begin
		nextState    = state;
		memRead      = 1'b0;
		memWrite     = 1'b0;
		pcWrite      = 1'b0;
		irWrite      = 1'b0;
		addrWrite    = 1'b0;
		dataWrite    = 1'b0;
		operandWrite = 1'b0;
		regWrite     = 1'b0;
		branch       = 1'b0;
		addrFromAlu  = 1'b0;
		loadToReg    = 1'b0;
		regDstSel    = (opcode == opRType) ? dstRd : dstRt;
		case (state)
			fetch: begin
				addrWrite = 1'b1; // Address register takes the PC
				nextState = fetchWait;
			end
			fetchWait: begin
				memRead = 1'b1;
				if (memReady) begin
					irWrite   = 1'b1;
					pcWrite   = 1'b1; // PC plus four
					nextState = decode;
				end
			end
			decode: begin
				operandWrite = 1'b1;
				nextState    = (isAluOp || isBranch || isLoad || isStore) ? execute : fetch;
			end
			execute: begin
				branch = isBranch;
				if (isAluOp)
					nextState = aluWriteback;
				else if (isLoad || isStore)
					nextState = memAddress;
				else
					nextState = fetch;
			end
			aluWriteback: begin
				regWrite  = 1'b1;
				nextState = fetch;
			end
			memAddress: begin
				addrWrite   = 1'b1;
				addrFromAlu = 1'b1;
				nextState   = memWait;
			end
			memWait: begin
				memRead   = isLoad;
				memWrite  = isStore;
				dataWrite = isLoad && memReady;
				if (memReady)
					nextState = isLoad ? loadWriteback : fetch;
			end
			loadWriteback: begin
				regWrite  = 1'b1;
				loadToReg = 1'b1;
				nextState = fetch;
			end
			default: nextState = fetch;
		endcase
	end

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  mipsPkg::aluMode_e aluMode,
	input  mipsPkg::funct_e   funct,
	input  logic [4:0]        shamt,
	input  mipsPkg::word_t    operandA,
	input  mipsPkg::word_t    operandB,
	output mipsPkg::word_t    result,
	output logic              zero
);
	import mipsPkg::*;

	logic lessSigned;
	logic lessUnsigned;

	assign lessSigned   = $signed(operandA) < $signed(operandB);
	assign lessUnsigned = operandA < operandB;

	always_comb begin
		result = '0;
		case (aluMode)
			aluFunct: begin
				case (funct)
					functAdd, functAddu: result = operandA + operandB; // No overflow trap
					functSub, functSubu: result = operandA - operandB;
					functAnd:            result = operandA & operandB;
					functOr:             result = operandA | operandB;
					functXor:            result = operandA ^ operandB;
					functNor:            result = ~(operandA | operandB);
					functSlt:            result[0] = lessSigned;
					functSltu:           result[0] = lessUnsigned;
					functSll:            result = operandB << shamt;
					functSrl:            result = operandB >> shamt;
					functSra:            result = word_t'($signed(operandB) >>> shamt);
					default:             result = '0;
				endcase
			end
			aluAdd:  result = operandA + operandB;
			aluSub:  result = operandA - operandB;
			aluSlt:  result[0] = lessSigned;
			aluSltu: result[0] = lessUnsigned;
			aluAnd:  result = operandA & operandB;
			aluOr:   result = operandA | operandB;
			aluXor:  result = operandA ^ operandB;
			aluLui:  result = operandB << 16; // Immediate to upper half
			default: result = '0;
		endcase
	end

	// Used for BEQ and BNE
	assign zero = (result == '0);

endmodule

`default_nettype wire

/* logic/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsDefs_defs.svh"

module registerFile (
	input  logic              CLK,
	input  logic              reset,
	input  logic              writeEnable,
	input  mipsPkg::regAddr_t readAddrA,
	input  mipsPkg::regAddr_t readAddrB,
	input  mipsPkg::regAddr_t writeAddr,
	input  mipsPkg::word_t    writeData,
	output mipsPkg::word_t    readDataA,
	output mipsPkg::word_t    readDataB
);
	import mipsPkg::*;

	word_t regs [`MIPS_REG_COUNT];

	for (genvar i = 0; i < `MIPS_REG_COUNT; i++) begin : gSlice
		if (i == 0) begin : gZero
			assign regs[i] = '0; // Hardwired zero
		end else begin : gReg
			word_t q;
			always_ff @(posedge CLK) begin
				if (reset)
					q <= '0;
				else if (writeEnable && writeAddr == regAddr_t'(i))
					q <= writeData;
			end
			assign regs[i] = q;
		end
	end

	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

/* logic/mipsPkg.sv */
`default_nettype none

`include "mipsDefs_defs.svh"

package mipsPkg;

	typedef logic [`MIPS_WORD_WIDTH-1:0] word_t;
	typedef logic [`MIPS_REG_ADDR_WIDTH-1:0] regAddr_t;

	typedef enum logic [5:0] {
		opRType = 6'b000000, // Operation in funct field
		opBeq   = 6'b000100,
		opBne   = 6'b000101,
		opBlez  = 6'b000110,
		opBgtz  = 6'b000111,
		opAddi  = 6'b001000,
		opAddiu = 6'b001001,
		opSlti  = 6'b001010,
		opSltiu = 6'b001011,
		opAndi  = 6'b001100,
		opOri   = 6'b001101,
		opXori  = 6'b001110,
		opLui   = 6'b001111,
		opLw    = 6'b100011,
		opSw    = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		functSll  = 6'b000000, // Shift amount from instruction
		functSrl  = 6'b000010,
		functSra  = 6'b000011,
		functAdd  = 6'b100000,
		functAddu = 6'b100001,
		functSub  = 6'b100010,
		functSubu = 6'b100011,
		functAnd  = 6'b100100,
		functOr   = 6'b100101,
		functXor  = 6'b100110,
		functNor  = 6'b100111,
		functSlt  = 6'b101010,
		functSltu = 6'b101011
	} funct_e;

	// ALU mode from the control unit, aluFunct defers to the funct field
	typedef enum logic [3:0] {
		aluFunct, aluAdd, aluSub, aluSlt, aluSltu, aluAnd, aluOr, aluXor, aluLui
	} aluMode_e;

	typedef enum logic {
		dstRt, // Immediates and loads
		dstRd  // R-type
	} regDstSel_e;

	typedef enum logic [1:0] {
		srcRegB, srcSignImm, srcZeroImm
	} aluSrcSel_e;

	typedef enum logic [3:0] {
		fetch, fetchWait, decode, execute,
		aluWriteback, memAddress, memWait, loadWriteback
	} cuState_e;

endpackage

`default_nettype wire

/* logic/mipsDefs_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Data and address width of the core
`define MIPS_WORD_WIDTH 32

// Architectural register file size
`define MIPS_REG_COUNT 32

// Register index width, log2 of the count
`define MIPS_REG_ADDR_WIDTH 5

// Address of the first instruction fetched after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif
